/* columnTransform.sv */
`timescale 1ns/10ps

module columnTransform (
	input logic clk,
	input logic rst,
	input dctPkg::coefT rowCoef [dctPkg::BlockSize],
	input logic rowValid,
	input dctPkg::indexT rowNumber,
	output dctPkg::coefT dctOut [dctPkg::BlockSize][dctPkg::BlockSize],
	output logic dctValid
);

	// Indexed [v][u] like the output matrix
	dctPkg::accT product [dctPkg::BlockSize][dctPkg::BlockSize];
	dctPkg::accT acc [dctPkg::BlockSize][dctPkg::BlockSize];

	logic productValid;
	dctPkg::indexT productRow;
	logic blockDone;

	// ------------------------------------------------------------------------
	// Multiply stage
	// ------------------------------------------------------------------------
	// Row y contributes C[v][y] * rowCoef[u] to every output entry
	always_ff @(posedge clk) begin
		if (rowValid) begin
			for (int v = 0; v < dctPkg::BlockSize; v++) begin
				for (int u = 0; u < dctPkg::BlockSize; u++) begin
					product[v][u] <= rowCoef[u] * dctPkg::CosTable[v][rowNumber];
				end
			end
			productRow <= rowNumber;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			productValid <= 1'b0;
		end else begin
			productValid <= rowValid;
		end
	end

	// ------------------------------------------------------------------------
	// Accumulate stage
	// ------------------------------------------------------------------------
	// Row 0 opens a new block so its products load the sums
	always_ff @(posedge clk) begin
		if (productValid) begin
			for (int v = 0; v < dctPkg::BlockSize; v++) begin
				for (int u = 0; u < dctPkg::BlockSize; u++) begin
					if (productRow == '0) begin
						acc[v][u] <= product[v][u];
					end else begin
						acc[v][u] <= acc[v][u] + product[v][u];
					end
				end
			end
		end
	end

	// Set once the last row of a block has been added
	always_ff @(posedge clk) begin
		if (rst) begin
			blockDone <= 1'b0;
		end else begin
			blockDone <= productValid
				&& productRow == dctPkg::indexT'(dctPkg::BlockSize - 1);
		end
	end

	// ------------------------------------------------------------------------
	// Output stage
	// ------------------------------------------------------------------------
	// Matrix holds until the next block completes
	always_ff @(posedge clk) begin
		if (rst) begin
			dctValid <= 1'b0;
			for (int v = 0; v < dctPkg::BlockSize; v++) begin
				for (int u = 0; u < dctPkg::BlockSize; u++) begin
					dctOut[v][u] <= '0;
				end
			end
		end else begin
			dctValid <= blockDone;
			if (blockDone) begin
				for (int v = 0; v < dctPkg::BlockSize; v++) begin
					for (int u = 0; u < dctPkg::BlockSize; u++) begin
						dctOut[v][u] <= dctPkg::roundQ14(acc[v][u]);
					end
				end
			end
		end
	end

endmodule

/* dctPkg.sv */
package dctPkg;

	// ------------------------------------------------------------------------
	// Widths and counts
	// ------------------------------------------------------------------------
	localparam int PixelWidth = 8;
	localparam int BlockSize = 8;
	localparam int IndexWidth = 3;
	localparam int LevelShift = 128;

	// Q14 fixed point, round bit sits just below the binary point
	localparam int CoefFracBits = 14;

	localparam int CosWidth = 16;
	localparam int CoefWidth = 11;
	localparam int AccWidth = 32;

	typedef logic [PixelWidth-1:0] pixelT;
	typedef logic [IndexWidth-1:0] indexT;
	typedef logic signed [CosWidth-1:0] cosT;
	typedef logic signed [CoefWidth-1:0] coefT;
	typedef logic signed [AccWidth-1:0] accT;

	// ------------------------------------------------------------------------
	// Cosine constants
	// ------------------------------------------------------------------------
	// Q14 value of c(k)*cos(m*pi/16)
	// C4 carries the 1/sqrt(8) scale of the DC row
	localparam cosT CosC4 = 16'sd5793;
	localparam cosT CosC1 = 16'sd8035;
	localparam cosT CosC2 = 16'sd7568;
	localparam cosT CosC3 = 16'sd6811;
	localparam cosT CosC5 = 16'sd4551;
	localparam cosT CosC6 = 16'sd3135;
	localparam cosT CosC7 = 16'sd1598;

	// Indexed [frequency][sample position]
	localparam cosT CosTable [BlockSize][BlockSize] = '{
		'{ CosC4,  CosC4,  CosC4,  CosC4,  CosC4,  CosC4,  CosC4,  CosC4},
		'{ CosC1,  CosC3,  CosC5,  CosC7, -CosC7, -CosC5, -CosC3, -CosC1},
		'{ CosC2,  CosC6, -CosC6, -CosC2, -CosC2, -CosC6,  CosC6,  CosC2},
		'{ CosC3, -CosC7, -CosC1, -CosC5,  CosC5,  CosC1,  CosC7, -CosC3},
		'{ CosC4, -CosC4, -CosC4,  CosC4,  CosC4, -CosC4, -CosC4,  CosC4},
		'{ CosC5, -CosC1,  CosC7,  CosC3, -CosC3, -CosC7,  CosC1, -CosC5},
		'{ CosC6, -CosC2,  CosC2, -CosC6, -CosC6,  CosC2, -CosC2,  CosC6},
		'{ CosC7, -CosC5,  CosC3, -CosC1,  CosC1, -CosC3,  CosC5, -CosC7}
	};

	// ------------------------------------------------------------------------
	// Rounding
	// ------------------------------------------------------------------------
	// Drop the fraction and round half up on bit 13
	function automatic coefT roundQ14(input accT acc);
		accT shifted;
		shifted = (acc >>> CoefFracBits) + accT'(acc[CoefFracBits-1]);
		return coefT'(shifted);
	endfunction

endpackage

/* dctTop.f */
+incdir+.
dctPkg.sv
pixelSequencer.sv
rowTransform.sv
columnTransform.sv
dctTop.sv
dctTop_tb.sv

/* dctTop.sv */
`timescale 1ns/10ps

module dctTop (
	input logic clk,
	input logic rst,
	input logic enable,
	input dctPkg::pixelT pixel,
	output dctPkg::coefT dctOut [dctPkg::BlockSize][dctPkg::BlockSize],
	output logic dctValid
);

	dctPkg::indexT colIndex;
	logic rowEnd;
	dctPkg::indexT rowIndex;

	// Row pass results, one row of horizontal frequencies at a time
	dctPkg::coefT rowCoef [dctPkg::BlockSize];
	logic rowValid;
	dctPkg::indexT rowNumber;

	pixelSequencer sequencer (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.colIndex(colIndex),
		.rowEnd(rowEnd),
		.rowIndex(rowIndex)
	);

	rowTransform rowPass (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.pixel(pixel),
		.colIndex(colIndex),
		.rowEnd(rowEnd),
		.rowIndex(rowIndex),
		.rowCoef(rowCoef),
		.rowValid(rowValid),
		.rowNumber(rowNumber)
	);

	// Column pass overlaps the row pass of the following row
	columnTransform columnPass (
		.clk(clk),
		.rst(rst),
		.rowCoef(rowCoef),
		.rowValid(rowValid),
		.rowNumber(rowNumber),
		.dctOut(dctOut),
		.dctValid(dctValid)
	);

endmodule

/* dctModel.svh */
`ifndef DCT_MODEL_SVH
`define DCT_MODEL_SVH

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------
	// Q14 value of c(k)*cos((2n+1)*k*pi/16) folded onto the named constants
	function automatic int cosQ14(input int k, input int n);
		int m;
		int mag;
		bit negate;
		negate = 1'b0;
		m = ((2 * n + 1) * k) % 32;
		if (m > 16) begin
			m = 32 - m;
		end
		if (m > 8) begin
			m = 16 - m;
			negate = 1'b1;
		end
		// The DC scale 1/sqrt(8) equals cos(pi/4)/2
		case (m)
			1: mag = dctPkg::CosC1;
			2: mag = dctPkg::CosC2;
			3: mag = dctPkg::CosC3;
			5: mag = dctPkg::CosC5;
			6: mag = dctPkg::CosC6;
			7: mag = dctPkg::CosC7;
			default: mag = dctPkg::CosC4;
		endcase
		return negate ? -mag : mag;
	endfunction

	// Add half an LSB, then drop the fraction
	function automatic int roundHalfUp(input longint acc);
		longint half;
		half = longint'(1) <<< (dctPkg::CoefFracBits - 1);
		return int'((acc + half) >>> dctPkg::CoefFracBits);
	endfunction

	task automatic computeExpected(input int slot);
		longint acc;
		int rowRes [dctPkg::BlockSize][dctPkg::BlockSize];
		// Row pass on level shifted pixels
		for (int y = 0; y < dctPkg::BlockSize; y++) begin
			for (int u = 0; u < dctPkg::BlockSize; u++) begin
				acc = 0;
				for (int x = 0; x < dctPkg::BlockSize; x++) begin
					acc += longint'((blockPix[slot][y * dctPkg::BlockSize + x]
						- dctPkg::LevelShift) * cosQ14(u, x));
				end
				rowRes[y][u] = roundHalfUp(acc);
			end
		end
		// Column pass over the rounded row results
		for (int v = 0; v < dctPkg::BlockSize; v++) begin
			for (int u = 0; u < dctPkg::BlockSize; u++) begin
				acc = 0;
				for (int y = 0; y < dctPkg::BlockSize; y++) begin
					acc += longint'(rowRes[y][u] * cosQ14(v, y));
				end
				expected[slot][v][u] = roundHalfUp(acc);
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// Stimulus and checking
	// ------------------------------------------------------------------------
	// 16 bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	// One step per pixel bit
	function automatic dctPkg::pixelT randomPixel();
		dctPkg::pixelT value;
		value = '0;
		for (int i = 0; i < dctPkg::PixelWidth; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[dctPkg::PixelWidth-2:0], lfsrState[0]};
		end
		return value;
	endfunction

	function automatic void compareMatrix(input int slot);
		for (int v = 0; v < dctPkg::BlockSize; v++) begin
			for (int u = 0; u < dctPkg::BlockSize; u++) begin
				if (int'(dctOut[v][u]) != expected[slot][v][u]) begin
					valueErrors++;
					$display("ERR %0t dctOut[%0d][%0d] got %0d expected %0d",
						$time, v, u, dctOut[v][u], expected[slot][v][u]);
				end
			end
		end
	endfunction

	// Advance to the next falling edge and account for any valid pulse
	task automatic nextCycle();
		@(negedge clk);
		if (dctValid) begin
			if (pulseCount < pendingBlocks) begin
				compareMatrix(pulseCount);
			end else begin
				otherErrors++;
				$display("Unexpected dctValid pulse at %0t", $time);
			end
			pulseCount++;
		end
	endtask

	task automatic driveBlock(input int slot);
		for (int i = 0; i < PixelsPerBlock; i++) begin
			nextCycle();
			enable = 1'b1;
			pixel = dctPkg::pixelT'(blockPix[slot][i]);
		end
	endtask

`endif

/* dctTop_tb.sv */
`timescale 1ns/10ps

module dctTop_tb;

	localparam int MaxBlocks = 4;
	localparam int PixelsPerBlock = dctPkg::BlockSize * dctPkg::BlockSize;
	localparam int TimeoutCycles = 100;

	logic clk;
	logic rst;
	logic enable;
	dctPkg::pixelT pixel;
	dctPkg::coefT dctOut [dctPkg::BlockSize][dctPkg::BlockSize];
	logic dctValid;

	int valueErrors;
	int otherErrors;
	logic [15:0] lfsrState;

	// Pixels in raster order and the model result, one slot per block
	int blockPix [MaxBlocks][PixelsPerBlock];
	int expected [MaxBlocks][dctPkg::BlockSize][dctPkg::BlockSize];

	// Valid pulses seen and blocks still owed in the current stream
	int pulseCount;
	int pendingBlocks;

	`include "dctModel.svh"

	dctTop DUT (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.pixel(pixel),
		.dctOut(dctOut),
		.dctValid(dctValid)
	);

	always #2 clk = ~clk;

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------
	function automatic void fillFlat(input int slot, input int value);
		for (int i = 0; i < PixelsPerBlock; i++) begin
			blockPix[slot][i] = value;
		end
	endfunction

	function automatic void loadRandom(input int slot);
		for (int i = 0; i < PixelsPerBlock; i++) begin
			blockPix[slot][i] = int'(randomPixel());
		end
	endfunction

	task automatic startStream(input int count);
		pulseCount = 0;
		pendingBlocks = count;
		for (int s = 0; s < count; s++) begin
			computeExpected(s);
		end
	endtask

	// Drop enable and wait for every owed pulse, then watch for extras
	task automatic finishStream();
		int waited;
		nextCycle();
		enable = 1'b0;
		waited = 0;
		while (pulseCount < pendingBlocks && waited < TimeoutCycles) begin
			nextCycle();
			waited++;
		end
		if (pulseCount < pendingBlocks) begin
			otherErrors++;
			$display("Timed out at %0t waiting for dctValid, saw %0d of %0d pulses",
				$time, pulseCount, pendingBlocks);
		end
		repeat (8) nextCycle();
	endtask

	// A flat block has only a DC term
	function automatic void verifyFlat(input int dc);
		int want;
		for (int v = 0; v < dctPkg::BlockSize; v++) begin
			for (int u = 0; u < dctPkg::BlockSize; u++) begin
				want = (v == 0 && u == 0) ? dc : 0;
				if (int'(dctOut[v][u]) != want) begin
					valueErrors++;
					$display("ERR %0t dctOut[%0d][%0d] got %0d expected %0d",
						$time, v, u, dctOut[v][u], want);
				end
			end
		end
	endfunction

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic resetIdle();
		startStream(0);
		repeat (20) nextCycle();
		verifyFlat(0);
	endtask

	// Mid gray maps to zero after the level shift
	task automatic midGrayBlock();
		logic expectValid;
		fillFlat(0, dctPkg::LevelShift);
		startStream(1);
		driveBlock(0);
		// Falling edge n sits half a cycle after edge n past the one that took pixel 64
		for (int n = 0; n <= 6; n++) begin
			nextCycle();
			if (n == 0) begin
				enable = 1'b0;
			end
			expectValid = (n == 5);
			if (dctValid !== expectValid) begin
				otherErrors++;
				$display("ERR %0t dctValid got %0b expected %0b", $time, dctValid, expectValid);
			end
		end
		finishStream();
		verifyFlat(0);
	endtask

	task automatic flatBlock(input int value);
		fillFlat(0, value);
		startStream(1);
		driveBlock(0);
		finishStream();
		verifyFlat(expected[0][0][0]);
	endtask

	task automatic randomStream();
		for (int s = 0; s < 3; s++) begin
			loadRandom(s);
		end
		startStream(3);
		for (int s = 0; s < 3; s++) begin
			driveBlock(s);
		end
		finishStream();
	endtask

	// A partial block must never complete
	task automatic droppedEnable();
		loadRandom(0);
		startStream(0);
		for (int i = 0; i < 30; i++) begin
			nextCycle();
			enable = 1'b1;
			pixel = dctPkg::pixelT'(blockPix[0][i]);
		end
		nextCycle();
		enable = 1'b0;
		repeat (20) nextCycle();
		loadRandom(0);
		startStream(1);
		driveBlock(0);
		finishStream();
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		enable = 1'b0;
		pixel = '0;
		valueErrors = 0;
		otherErrors = 0;
		pulseCount = 0;
		pendingBlocks = 0;
		lfsrState = 16'd69;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		resetIdle();
		midGrayBlock();
		flatBlock(200);
		flatBlock(0);
		randomStream();
		droppedEnable();

		$display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* pixelSequencer.sv */
`timescale 1ns/10ps

module pixelSequencer (
	input logic clk,
	input logic rst,
	input logic enable,
	output dctPkg::indexT colIndex,
	output logic rowEnd,
	output dctPkg::indexT rowIndex
);

	// Position of the next pixel inside the block, row in the upper bits
	logic [2*dctPkg::IndexWidth-1:0] position;
	dctPkg::indexT rowPos;

	assign colIndex = position[dctPkg::IndexWidth-1:0];
	assign rowPos = position[2*dctPkg::IndexWidth-1:dctPkg::IndexWidth];

	// Dropping enable abandons whatever block was in progress
	always_ff @(posedge clk) begin
		if (rst) begin
			position <= '0;
		end else if (!enable) begin
			position <= '0;
		end else begin
			position <= position + 1'b1;
		end
	end

	// Strobe after the last pixel of a row, row number held until the next one
	always_ff @(posedge clk) begin
		if (rst) begin
			rowEnd <= 1'b0;
			rowIndex <= '0;
		end else if (enable && colIndex == dctPkg::indexT'(dctPkg::BlockSize - 1)) begin
			rowEnd <= 1'b1;
			rowIndex <= rowPos;
		end else begin
			rowEnd <= 1'b0;
		end
	end

endmodule

/* rowTransform.sv */
`timescale 1ns/10ps

module rowTransform (
	input logic clk,
	input logic rst,
	input logic enable,
	input dctPkg::pixelT pixel,
	input dctPkg::indexT colIndex,
	input logic rowEnd,
	input dctPkg::indexT rowIndex,
	output dctPkg::coefT rowCoef [dctPkg::BlockSize],
	output logic rowValid,
	output dctPkg::indexT rowNumber
);

	// Level shifted sample in -128..127
	logic signed [dctPkg::PixelWidth:0] sample;

	dctPkg::accT product [dctPkg::BlockSize];
	dctPkg::accT acc [dctPkg::BlockSize];

	logic productValid;
	logic firstTerm;
	logic rowEndDly;

	assign sample = (dctPkg::PixelWidth + 1)'(pixel)
		- (dctPkg::PixelWidth + 1)'(dctPkg::LevelShift);

	// ------------------------------------------------------------------------
	// Multiply stage
	// ------------------------------------------------------------------------
	// One product per frequency for the pixel accepted on this edge
	always_ff @(posedge clk) begin
		if (enable) begin
			for (int k = 0; k < dctPkg::BlockSize; k++) begin
				product[k] <= sample * dctPkg::CosTable[k][colIndex];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			productValid <= 1'b0;
			firstTerm <= 1'b0;
			rowEndDly <= 1'b0;
		end else begin
			productValid <= enable;
			firstTerm <= (colIndex == '0);
			rowEndDly <= rowEnd;
		end
	end

	// ------------------------------------------------------------------------
	// Accumulate stage
	// ------------------------------------------------------------------------
	// First pixel of a row starts a fresh sum
	always_ff @(posedge clk) begin
		if (productValid) begin
			for (int k = 0; k < dctPkg::BlockSize; k++) begin
				acc[k] <= firstTerm ? product[k] : acc[k] + product[k];
			end
		end
	end

	// Last product landed on the previous edge, so the sums are complete here
	always_ff @(posedge clk) begin
		if (rowEndDly) begin
			for (int k = 0; k < dctPkg::BlockSize; k++) begin
				rowCoef[k] <= dctPkg::roundQ14(acc[k]);
			end
			rowNumber <= rowIndex;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rowValid <= 1'b0;
		end else begin
			rowValid <= rowEndDly;
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the DCT testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f dctTop.f --top-module dctTop_tb -o dctSim \
	&& ./obj_dir/dctSim > sim.log 2>&1 \
	|| { echo "Simulation build or run error"; exit 1; }

cat sim.log
grep -q "^Testbench passed$" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }
